// File: pipe_core.f
common/pipe_pkg.sv
design/regfile.sv
design/csr_file.sv
design/decode_stage.sv
design/hazard_forward.sv
design/execute_stage.sv
design/mem_stage.sv
design/pipe_core.sv
dv/pipe_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the pipe_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f pipe_core.f \
    --top-module pipe_core_tb \
    -o sim_pipe_core

output="$(./obj_dir/sim_pipe_core)"
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// File: dv/pipe_core_tb.sv
// testbench for pipe_core with an LFSR micro-op stream, memory responder,
// reference model with retire and store queues, checks and timeout
`timescale 1ns/1ns

module pipe_core_tb
    import pipe_pkg::*;
();

    localparam int NUM_OPS  = 400;
    localparam int PROG_LEN = NUM_OPS + 4;
    localparam int TIMEOUT  = NUM_OPS * 6 + 100;
    localparam word_t POISON = 32'hdead_beef;

    logic     clk, rst, instr_valid, instr_ready;
    word_t    instr;
    logic     mem_req, mem_we, mem_rvalid, mem_wready;
    word_t    mem_addr, mem_wdata, mem_rdata;
    logic     retire_valid;
    reg_idx_t retire_rd;
    word_t    retire_data;

    word_t       prog [PROG_LEN];
    word_t       resp_mem [256];
    word_t       model_mem [256];
    word_t       model_regs [32];
    word_t       model_csrs [4];
    logic [36:0] exp_retire [$];
    logic [63:0] exp_store [$];

    logic [31:0] lfsr;
    int          errors, checks, cycles, pc, settle;
    int          model_retires, seen_retires, wait_cnt;
    logic        busy, done, timed_out;
    logic        nxt_rvalid, nxt_wready;
    word_t       nxt_rdata;

    pipe_core dut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t fill_word(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {a, ~a, a ^ 8'h3c, a + 8'd77};
    endfunction

    function automatic word_t make_op();
        word_t r;
        op_t   op;
        r = rand_bits(3);
        op = r[2:0];
        // spare code becomes an extra load
        if (op == 3'd7) begin
            op = OP_LW;
        end
        // registers limited to x0..x7 so hazards are frequent
        r = rand_bits(23);
        return {op, 2'b00, r[22:20], 2'b00, r[19:17], 2'b00, r[16:14], r[13:12], r[11:0]};
    endfunction

    task automatic model_exec(input word_t w);
        op_t      op;
        reg_idx_t rd, rs1, rs2;
        csr_idx_t c;
        word_t    imm, a, b, res, addr;
        logic     wr;
        op   = w[31:29];
        rd   = w[28:24];
        rs1  = w[23:19];
        rs2  = w[18:14];
        c    = w[13:12];
        imm  = {{20{w[11]}}, w[11:0]};
        a    = model_regs[rs1];
        b    = model_regs[rs2];
        addr = a + imm;
        wr   = 1'b1;
        res  = '0;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_ADDI: res = addr;
            OP_LW:   res = model_mem[addr[9:2]];
            OP_SW: begin
                model_mem[addr[9:2]] = b;
                exp_store.push_back({addr, b});
                wr = 1'b0;
            end
            // old CSR value goes to rd
            OP_CSRRW: begin
                res = model_csrs[c];
                model_csrs[c] = a;
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != '0) begin
            model_regs[rd] = res;
            exp_retire.push_back({rd, res});
            model_retires++;
        end
    endtask

    task automatic check_idle(input string name);
        checks++;
        assert (!retire_valid && !mem_req && !mem_we && instr_ready) else begin
            errors++;
            $display("Fail %s: expected valid/req/we/ready 0001, actual %b%b%b%b",
                     name, retire_valid, mem_req, mem_we, instr_ready);
        end
    endtask

    task automatic check_retire();
        logic [36:0] exp;
        if (retire_valid) begin
            checks++;
            assert (exp_retire.size() != 0) else begin
                errors++;
                $display("register x%0d retired with nothing left to retire", retire_rd);
            end
            if (exp_retire.size() != 0) begin
                exp = exp_retire.pop_front();
                seen_retires++;
                assert (retire_rd == exp[36:32] && retire_data == exp[31:0]) else begin
                    errors++;
                    $display("Fail retire: expected x%0d %h, actual x%0d %h",
                             exp[36:32], exp[31:0], retire_rd, retire_data);
                end
            end
        end
    endtask

    // completes the access in the response cycle, then counts out the next latency
    task automatic serve_memory();
        logic [63:0] exp;
        nxt_rvalid = 1'b0;
        nxt_wready = 1'b0;
        nxt_rdata  = POISON;
        if (mem_rvalid || mem_wready) begin
            assert (mem_req) else begin
                errors++;
                $display("memory request dropped before its response");
            end
            if (mem_req && mem_we) begin
                checks++;
                assert (exp_store.size() != 0) else begin
                    errors++;
                    $display("store to %h completed with no store expected", mem_addr);
                end
                if (exp_store.size() != 0) begin
                    exp = exp_store.pop_front();
                    assert (mem_addr == exp[63:32] && mem_wdata == exp[31:0]) else begin
                        errors++;
                        $display("Fail store: expected %h <- %h, actual %h <- %h",
                                 exp[63:32], exp[31:0], mem_addr, mem_wdata);
                    end
                end
                resp_mem[mem_addr[9:2]] = mem_wdata;
            end
            busy = 1'b0;
        end else if (mem_req) begin
            if (!busy) begin
                busy = 1'b1;
                wait_cnt = int'(rand_bits(2));
            end else begin
                wait_cnt--;
            end
            if (wait_cnt == 0) begin
                nxt_wready = mem_we;
                nxt_rvalid = !mem_we;
                nxt_rdata  = mem_we ? POISON : resp_mem[mem_addr[9:2]];
            end
        end
    endtask

    task automatic drive_inputs();
        word_t r;
        mem_rvalid = nxt_rvalid;
        mem_wready = nxt_wready;
        mem_rdata  = nxt_rdata;
        r = rand_bits(2);
        // about one cycle in four without a fetch
        instr_valid = (pc < PROG_LEN) && (r[1:0] != 2'b00);
        instr = (pc < PROG_LEN) ? prog[pc] : '0;
    endtask

    initial begin
        lfsr = 32'h65e4050a;
        errors = 0;
        checks = 0;
        cycles = 0;
        pc = 0;
        settle = 0;
        model_retires = 0;
        seen_retires = 0;
        wait_cnt = 0;
        busy = 1'b0;
        done = 1'b0;
        timed_out = 1'b0;
        nxt_rvalid = 1'b0;
        nxt_wready = 1'b0;
        nxt_rdata = POISON;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        mem_rvalid = 1'b0;
        mem_wready = 1'b0;
        mem_rdata = POISON;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = (i < NUM_OPS) ? make_op() : '0;
        end
        for (int i = 0; i < 256; i++) begin
            resp_mem[i] = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            model_csrs[i] = '0;
        end

        for (int k = 0; k < 16; k++) begin
            @(posedge clk);
            if (k > 0) begin
                check_idle("reset");
            end
        end
        #5;
        rst = 1'b0;
        drive_inputs();

        while (!done && !timed_out) begin
            @(posedge clk);
            cycles++;
            // nothing accepted yet, so the core must still look idle
            if (pc == 0) begin
                check_idle("after_reset");
            end
            check_retire();
            serve_memory();
            if (instr_valid && instr_ready) begin
                model_exec(prog[pc]);
                pc++;
            end
            if (pc == PROG_LEN && exp_retire.size() == 0 && exp_store.size() == 0) begin
                settle++;
            end
            done = (settle == 4);
            timed_out = (cycles >= TIMEOUT);
            #5;
            drive_inputs();
        end

        assert (!timed_out) else begin
            errors++;
            $display("timeout after %0d cycles, %0d of %0d micro-ops accepted",
                     cycles, pc, PROG_LEN);
        end
        checks++;
        assert (seen_retires == model_retires && exp_retire.size() == 0) else begin
            errors++;
            $display("retired %0d registers, the model expected %0d",
                     seen_retires, model_retires);
        end
        assert (exp_store.size() == 0) else begin
            errors++;
            $display("%0d expected stores never completed", exp_store.size());
        end
        $display("checks %0d, errors %0d, retires %0d of %0d, cycles %0d",
                 checks, errors, seen_retires, model_retires, cycles);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: design/pipe_core.sv
// pipeline core top, stages, hazard unit and writeback loop
`timescale 1ns/1ns

module pipe_core
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     instr_valid,
    input  word_t    instr,
    output logic     instr_ready,
    output logic     mem_req,
    output logic     mem_we,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    input  logic     mem_rvalid,
    input  word_t    mem_rdata,
    input  logic     mem_wready,
    output logic     retire_valid,
    output reg_idx_t retire_rd,
    output word_t    retire_data
);

    logic     stall, flush_wb, load_done, store_done;
    op_t      id_op, mem_op;
    reg_idx_t id_rd, id_rs1, id_rs2, ex_rs1, ex_rs2, mem_rd, wb_rd;
    csr_idx_t id_csr, ex_csr, mem_csr, wb_csr;
    word_t    id_imm, id_rs1_data, id_rs2_data, id_csr_data;
    logic     id_write_gpr, id_write_csr, id_mem_to_reg;
    logic     seg_fwd_rs1, seg_fwd_rs2, seg_fwd_csr;
    logic     ex_fwd_rs1, ex_fwd_rs2, ex_fwd_csr;
    word_t    ex_fwd_rs1_data, ex_fwd_rs2_data, ex_fwd_csr_data;
    logic     mem_valid, mem_write_gpr, mem_write_csr, mem_to_reg;
    word_t    mem_alu_out, mem_csr_out, mem_store_data, load_data;
    logic     wb_write_gpr, wb_write_csr;
    word_t    wb_gpr_data, wb_csr_data;

    decode_stage u_decode (
        .clk, .rst, .instr,
        .id_op, .id_rd, .id_rs1, .id_rs2, .id_csr, .id_imm,
        .id_write_gpr, .id_write_csr, .id_mem_to_reg,
        .id_rs1_data, .id_rs2_data, .id_csr_data,
        .seg_fwd_rs1, .seg_fwd_rs2, .seg_fwd_csr,
        // writeback loops back into the register files
        .gpr_we     (wb_write_gpr),
        .gpr_wd_idx (wb_rd),
        .wb_gpr_data,
        .csr_we     (wb_write_csr),
        .csr_wr_idx (wb_csr),
        .wb_csr_data
    );

    hazard_forward u_hazard (
        .instr_valid, .load_done, .store_done,
        .id_rs1, .id_rs2, .id_csr, .ex_rs1, .ex_rs2, .ex_csr,
        .mem_rd, .mem_csr, .mem_write_gpr, .mem_write_csr, .mem_to_reg,
        .mem_alu_out, .mem_csr_out,
        .mem_rdata  (load_data),
        .wb_rd, .wb_csr, .wb_write_gpr, .wb_write_csr, .wb_gpr_data, .wb_csr_data,
        .stall, .flush_wb, .instr_ready,
        .ex_fwd_rs1, .ex_fwd_rs2, .ex_fwd_csr,
        .ex_fwd_rs1_data, .ex_fwd_rs2_data, .ex_fwd_csr_data,
        .seg_fwd_rs1, .seg_fwd_rs2, .seg_fwd_csr
    );

    execute_stage u_execute (
        .clk, .rst, .stall,
        .id_op, .id_rd, .id_rs1, .id_rs2, .id_csr, .id_imm,
        .id_write_gpr, .id_write_csr, .id_mem_to_reg,
        .id_rs1_data, .id_rs2_data, .id_csr_data,
        .ex_fwd_rs1, .ex_fwd_rs2, .ex_fwd_csr,
        .ex_fwd_rs1_data, .ex_fwd_rs2_data, .ex_fwd_csr_data,
        .ex_rs1, .ex_rs2, .ex_csr,
        .mem_valid, .mem_op, .mem_rd, .mem_csr, .mem_write_gpr, .mem_write_csr,
        .mem_to_reg, .mem_alu_out, .mem_csr_out, .mem_store_data
    );

    mem_stage u_mem (
        .clk, .rst, .stall, .flush_wb,
        .mem_valid, .mem_op, .mem_rd, .mem_csr, .mem_write_gpr, .mem_write_csr,
        .mem_to_reg, .mem_alu_out, .mem_csr_out, .mem_store_data,
        .mem_req, .mem_we, .mem_addr, .mem_wdata,
        .mem_rvalid, .mem_rdata, .mem_wready,
        .load_done, .store_done, .load_data,
        .wb_rd, .wb_csr, .wb_write_gpr, .wb_write_csr, .wb_gpr_data, .wb_csr_data,
        .retire_valid, .retire_rd, .retire_data
    );

endmodule

// File: design/mem_stage.sv
// data port driver, access completion tracking and MEM/WB register
`timescale 1ns/1ns

module mem_stage
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush_wb,
    input  logic     mem_valid,
    input  op_t      mem_op,
    input  reg_idx_t mem_rd,
    input  csr_idx_t mem_csr,
    input  logic     mem_write_gpr,
    input  logic     mem_write_csr,
    input  logic     mem_to_reg,
    input  word_t    mem_alu_out,
    input  word_t    mem_csr_out,
    input  word_t    mem_store_data,
    output logic     mem_req,
    output logic     mem_we,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    input  logic     mem_rvalid,
    input  word_t    mem_rdata,
    input  logic     mem_wready,
    output logic     load_done,
    output logic     store_done,
    output word_t    load_data,
    output reg_idx_t wb_rd,
    output csr_idx_t wb_csr,
    output logic     wb_write_gpr,
    output logic     wb_write_csr,
    output word_t    wb_gpr_data,
    output word_t    wb_csr_data,
    output logic     retire_valid,
    output reg_idx_t retire_rd,
    output word_t    retire_data
);

    logic  is_load, is_store, acc_done_q;
    word_t rdata_hold;

    assign is_load  = mem_valid && (mem_op == OP_LW);
    assign is_store = mem_valid && (mem_op == OP_SW);

    // request drops once the access has finished under a stall
    assign mem_req   = (is_load || is_store) && !acc_done_q;
    assign mem_we    = is_store && !acc_done_q;
    assign mem_addr  = mem_alu_out;
    assign mem_wdata = mem_store_data;

    assign load_done  = !is_load || acc_done_q || mem_rvalid;
    assign store_done = !is_store || acc_done_q || mem_wready;

    always_ff @(posedge clk) begin
        if (rst || !stall) begin
            acc_done_q <= 1'b0;
        end else if (mem_req && ((is_load && mem_rvalid) || (is_store && mem_wready))) begin
            acc_done_q <= 1'b1;
        end
    end

    // rdata only lives for the rvalid cycle
    always_ff @(posedge clk) begin
        if (mem_req && is_load && mem_rvalid) begin
            rdata_hold <= mem_rdata;
        end
    end

    assign load_data = acc_done_q ? rdata_hold : mem_rdata;

    always_ff @(posedge clk) begin
        if (rst || flush_wb) begin
            wb_write_gpr <= 1'b0;
            wb_write_csr <= 1'b0;
        end else begin
            wb_write_gpr <= mem_write_gpr;
            wb_write_csr <= mem_write_csr;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd       <= mem_rd;
        wb_csr      <= mem_csr;
        wb_gpr_data <= mem_to_reg ? load_data : mem_alu_out;
        wb_csr_data <= mem_csr_out;
    end

    assign retire_valid = wb_write_gpr;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_gpr_data;

endmodule

// File: design/execute_stage.sv
// ID/EX register with operand refresh, forwarding muxes, ALU and EX/MEM register
`timescale 1ns/1ns

module execute_stage
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  op_t      id_op,
    input  reg_idx_t id_rd,
    input  reg_idx_t id_rs1,
    input  reg_idx_t id_rs2,
    input  csr_idx_t id_csr,
    input  word_t    id_imm,
    input  logic     id_write_gpr,
    input  logic     id_write_csr,
    input  logic     id_mem_to_reg,
    input  word_t    id_rs1_data,
    input  word_t    id_rs2_data,
    input  word_t    id_csr_data,
    input  logic     ex_fwd_rs1,
    input  logic     ex_fwd_rs2,
    input  logic     ex_fwd_csr,
    input  word_t    ex_fwd_rs1_data,
    input  word_t    ex_fwd_rs2_data,
    input  word_t    ex_fwd_csr_data,
    output reg_idx_t ex_rs1,
    output reg_idx_t ex_rs2,
    output csr_idx_t ex_csr,
    output logic     mem_valid,
    output op_t      mem_op,
    output reg_idx_t mem_rd,
    output csr_idx_t mem_csr,
    output logic     mem_write_gpr,
    output logic     mem_write_csr,
    output logic     mem_to_reg,
    output word_t    mem_alu_out,
    output word_t    mem_csr_out,
    output word_t    mem_store_data
);

    logic     ex_valid, ex_write_gpr, ex_write_csr, ex_mem_to_reg;
    op_t      ex_op;
    reg_idx_t ex_rd;
    word_t    ex_imm, ex_rs1_q, ex_rs2_q, ex_csr_q;
    word_t    op_a, op_b, op_c, alu_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid      <= 1'b0;
            ex_op         <= OP_NOP;
            ex_write_gpr  <= 1'b0;
            ex_write_csr  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
        end else if (!stall) begin
            ex_valid      <= 1'b1;
            ex_op         <= id_op;
            ex_write_gpr  <= id_write_gpr;
            ex_write_csr  <= id_write_csr;
            ex_mem_to_reg <= id_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_rd    <= id_rd;
            ex_rs1   <= id_rs1;
            ex_rs2   <= id_rs2;
            ex_csr   <= id_csr;
            ex_imm   <= id_imm;
            ex_rs1_q <= id_rs1_data;
            ex_rs2_q <= id_rs2_data;
            ex_csr_q <= id_csr_data;
        end else begin
            // frozen, keep what a producer leaving WB would take away
            if (ex_fwd_rs1) ex_rs1_q <= ex_fwd_rs1_data;
            if (ex_fwd_rs2) ex_rs2_q <= ex_fwd_rs2_data;
            if (ex_fwd_csr) ex_csr_q <= ex_fwd_csr_data;
        end
    end

    assign op_a = ex_fwd_rs1 ? ex_fwd_rs1_data : ex_rs1_q;
    assign op_b = ex_fwd_rs2 ? ex_fwd_rs2_data : ex_rs2_q;
    assign op_c = ex_fwd_csr ? ex_fwd_csr_data : ex_csr_q;

    always_comb begin
        case (ex_op)
            OP_ADD:                  alu_out = op_a + op_b;
            OP_SUB:                  alu_out = op_a - op_b;
            OP_ADDI, OP_LW, OP_SW:   alu_out = op_a + ex_imm;
            // CSRRW returns the old value
            OP_CSRRW:                alu_out = op_c;
            default:                 alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid     <= 1'b0;
            mem_op        <= OP_NOP;
            mem_write_gpr <= 1'b0;
            mem_write_csr <= 1'b0;
            mem_to_reg    <= 1'b0;
        end else if (!stall) begin
            mem_valid     <= ex_valid;
            mem_op        <= ex_op;
            mem_write_gpr <= ex_write_gpr;
            mem_write_csr <= ex_write_csr;
            mem_to_reg    <= ex_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_rd         <= ex_rd;
            mem_csr        <= ex_csr;
            mem_alu_out    <= alu_out;
            mem_csr_out    <= op_a;
            mem_store_data <= op_b;
        end
    end

endmodule

// File: design/hazard_forward.sv
// hazard detection and forwarding, global stall and writeback flush
`timescale 1ns/1ns

module hazard_forward
    import pipe_pkg::*;
(
    input  logic     instr_valid,
    input  logic     load_done,
    input  logic     store_done,
    input  reg_idx_t id_rs1,
    input  reg_idx_t id_rs2,
    input  csr_idx_t id_csr,
    input  reg_idx_t ex_rs1,
    input  reg_idx_t ex_rs2,
    input  csr_idx_t ex_csr,
    input  reg_idx_t mem_rd,
    input  csr_idx_t mem_csr,
    input  logic     mem_write_gpr,
    input  logic     mem_write_csr,
    input  logic     mem_to_reg,
    input  word_t    mem_alu_out,
    input  word_t    mem_csr_out,
    input  word_t    mem_rdata,
    input  reg_idx_t wb_rd,
    input  csr_idx_t wb_csr,
    input  logic     wb_write_gpr,
    input  logic     wb_write_csr,
    input  word_t    wb_gpr_data,
    input  word_t    wb_csr_data,
    output logic     stall,
    output logic     flush_wb,
    output logic     instr_ready,
    output logic     ex_fwd_rs1,
    output logic     ex_fwd_rs2,
    output logic     ex_fwd_csr,
    output word_t    ex_fwd_rs1_data,
    output word_t    ex_fwd_rs2_data,
    output word_t    ex_fwd_csr_data,
    output logic     seg_fwd_rs1,
    output logic     seg_fwd_rs2,
    output logic     seg_fwd_csr
);

    logic first_rs1, first_rs2, first_csr;
    logic load_rs1, load_rs2;
    logic second_rs1, second_rs2, second_csr;
    logic mem_done;

    // producer in MEM, consumer in EX
    assign first_rs1 = (ex_rs1 == mem_rd) && mem_write_gpr && !mem_to_reg;
    assign first_rs2 = (ex_rs2 == mem_rd) && mem_write_gpr && !mem_to_reg;
    assign first_csr = (ex_csr == mem_csr) && mem_write_csr;

    // load in MEM, pipe waits on mem_rvalid so data comes from the port
    assign load_rs1 = (ex_rs1 == mem_rd) && mem_write_gpr && mem_to_reg;
    assign load_rs2 = (ex_rs2 == mem_rd) && mem_write_gpr && mem_to_reg;

    // producer in WB, consumer in EX
    assign second_rs1 = (ex_rs1 == wb_rd) && wb_write_gpr;
    assign second_rs2 = (ex_rs2 == wb_rd) && wb_write_gpr;
    assign second_csr = (ex_csr == wb_csr) && wb_write_csr;

    // producer in WB, consumer still in ID
    assign seg_fwd_rs1 = (id_rs1 == wb_rd) && wb_write_gpr;
    assign seg_fwd_rs2 = (id_rs2 == wb_rd) && wb_write_gpr;
    assign seg_fwd_csr = (id_csr == wb_csr) && wb_write_csr;

    assign ex_fwd_rs1 = first_rs1 || load_rs1 || second_rs1;
    assign ex_fwd_rs2 = first_rs2 || load_rs2 || second_rs2;
    assign ex_fwd_csr = first_csr || second_csr;

    // MEM wins over WB
    assign ex_fwd_rs1_data = first_rs1 ? mem_alu_out :
                             load_rs1  ? mem_rdata   : wb_gpr_data;
    assign ex_fwd_rs2_data = first_rs2 ? mem_alu_out :
                             load_rs2  ? mem_rdata   : wb_gpr_data;
    assign ex_fwd_csr_data = first_csr ? mem_csr_out : wb_csr_data;

    // whole pipe moves only with a fetch and no open access
    assign mem_done    = load_done && store_done;
    assign instr_ready = mem_done;
    assign stall       = !(instr_valid && mem_done);
    assign flush_wb    = stall;

endmodule

// File: design/decode_stage.sv
// micro-op field decode, register and CSR reads,
// and the writeback forward into the ID/EX inputs
`timescale 1ns/1ns

module decode_stage
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  word_t    instr,
    output op_t      id_op,
    output reg_idx_t id_rd,
    output reg_idx_t id_rs1,
    output reg_idx_t id_rs2,
    output csr_idx_t id_csr,
    output word_t    id_imm,
    output logic     id_write_gpr,
    output logic     id_write_csr,
    output logic     id_mem_to_reg,
    output word_t    id_rs1_data,
    output word_t    id_rs2_data,
    output word_t    id_csr_data,
    input  logic     seg_fwd_rs1,
    input  logic     seg_fwd_rs2,
    input  logic     seg_fwd_csr,
    // writeback side, also the register file write ports
    input  logic     gpr_we,
    input  reg_idx_t gpr_wd_idx,
    input  word_t    wb_gpr_data,
    input  logic     csr_we,
    input  csr_idx_t csr_wr_idx,
    input  word_t    wb_csr_data
);

    word_t rf_rs1, rf_rs2, rf_csr;

    assign id_op  = op_t'(instr[OP_HI:OP_LO]);
    assign id_rd  = instr[RD_HI:RD_LO];
    assign id_rs1 = instr[RS1_HI:RS1_LO];
    assign id_rs2 = instr[RS2_HI:RS2_LO];
    assign id_csr = instr[CSR_HI:CSR_LO];
    assign id_imm = {{20{instr[IMM_HI]}}, instr[IMM_HI:IMM_LO]};

    // only place x0 is checked, later stages trust write_gpr
    assign id_write_gpr  = (id_rd != '0) &&
                           (id_op inside {OP_ADD, OP_SUB, OP_ADDI, OP_LW, OP_CSRRW});
    assign id_write_csr  = (id_op == OP_CSRRW);
    assign id_mem_to_reg = (id_op == OP_LW);

    regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1      (id_rs1),
        .rs2      (id_rs2),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2),
        .we       (gpr_we),
        .wd_idx   (gpr_wd_idx),
        .wd       (wb_gpr_data)
    );

    csr_file u_csr_file (
        .clk     (clk),
        .rst     (rst),
        .rd_idx  (id_csr),
        .rd_data (rf_csr),
        .we      (csr_we),
        .wr_idx  (csr_wr_idx),
        .wr_data (wb_csr_data)
    );

    // WB result not yet in the files
    assign id_rs1_data = seg_fwd_rs1 ? wb_gpr_data : rf_rs1;
    assign id_rs2_data = seg_fwd_rs2 ? wb_gpr_data : rf_rs2;
    assign id_csr_data = seg_fwd_csr ? wb_csr_data : rf_csr;

endmodule

// File: design/csr_file.sv
// four-entry CSR file, one read and one write port
`timescale 1ns/1ns

module csr_file
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  csr_idx_t rd_idx,
    output word_t    rd_data,
    input  logic     we,
    input  csr_idx_t wr_idx,
    input  word_t    wr_data
);

    word_t csrs [4];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                csrs[i] <= '0;
            end
        end else if (we) begin
            csrs[wr_idx] <= wr_data;
        end
    end

    assign rd_data = csrs[rd_idx];

endmodule

// File: design/regfile.sv
// general register file, two combinational reads and one write port
`timescale 1ns/1ns

module regfile
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     we,
    input  reg_idx_t wd_idx,
    input  word_t    wd
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wd_idx] <= wd;
        end
    end

    // no write bypass, x0 hardwired to zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: common/pipe_pkg.sv
// word and index types, opcodes and micro-op field positions
package pipe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [1:0]  csr_idx_t;
    typedef logic [2:0]  op_t;

    // micro-op opcodes
    localparam op_t OP_NOP   = 3'd0;
    localparam op_t OP_ADD   = 3'd1;
    localparam op_t OP_SUB   = 3'd2;
    localparam op_t OP_ADDI  = 3'd3;
    localparam op_t OP_LW    = 3'd4;
    localparam op_t OP_SW    = 3'd5;
    localparam op_t OP_CSRRW = 3'd6;

    // field bounds inside the 32-bit micro-op
    localparam int OP_HI  = 31;
    localparam int OP_LO  = 29;
    localparam int RD_HI  = 28;
    localparam int RD_LO  = 24;
    localparam int RS1_HI = 23;
    localparam int RS1_LO = 19;
    localparam int RS2_HI = 18;
    localparam int RS2_LO = 14;
    localparam int CSR_HI = 13;
    localparam int CSR_LO = 12;
    // imm is sign-extended from bit 11
    localparam int IMM_HI = 11;
    localparam int IMM_LO = 0;

endpackage
